// File: common/fbp_defs.svh
`ifndef FBP_DEFS_SVH
`define FBP_DEFS_SVH

// address width into one projection line
`define FBP_S_WIDTH 4

// samples per projection line
`define FBP_LINE_SIZE 16

// raw signed sample from the host
`define FBP_SAMPLE_WIDTH 12

// signed filtered value as stored in the banks
`define FBP_FILT_WIDTH 16

// ramp filter order, fill delay is half of it
`define FBP_FIR_ORDER 2

`endif

// File: common/fbp_pkg.sv
`default_nettype none

`include "fbp_defs.svh"

package fbp_pkg;

    // address into a projection line
    typedef logic [`FBP_S_WIDTH-1:0] s_addr_t;

    // raw projection sample
    typedef logic signed [`FBP_SAMPLE_WIDTH-1:0] sample_t;

    // filtered value
    typedef logic signed [`FBP_FILT_WIDTH-1:0] filt_t;

    // fill controller states
    typedef enum logic [1:0] {
        ready_s,
        delay_s,
        fill_s
    } fill_state_t;

    // addresses from the two processing ports
    typedef struct packed {
        s_addr_t pr0;
        s_addr_t pr1;
    } pr_req_t;

    // read data back to the two processing ports
    typedef struct packed {
        filt_t pr0;
        filt_t pr1;
    } pr_rsp_t;

endpackage

`default_nettype wire

// File: design/ramp_fir.sv
`timescale 1ns/100ps
`default_nettype none

`include "fbp_defs.svh"

module ramp_fir
(
    input  wire logic            clk,
    input  wire logic            reset_n,
    input  wire logic            clear,
    input  wire fbp_pkg::sample_t sample,
    output fbp_pkg::filt_t       filt
);

    // sample history, one and two cycles back
    fbp_pkg::sample_t hist_0;
    fbp_pkg::sample_t hist_1;

    // taps widened to the filtered width
    fbp_pkg::filt_t x_next;
    fbp_pkg::filt_t x_mid;
    fbp_pkg::filt_t x_prev;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            hist_0 <= '0;
            hist_1 <= '0;
        end
        else if (clear)
        begin
            // new line, nothing before sample 0
            hist_0 <= '0;
            hist_1 <= '0;
        end
        else
        begin
            hist_0 <= sample;
            hist_1 <= hist_0;
        end
    end

    // signed sources, so these sign extend
    assign x_next = sample;
    assign x_mid  = hist_0;
    assign x_prev = hist_1;

    // taps (-1, 2, -1) centered on the sample one cycle back.
    // the history is registered, the sum follows the current sample
    // so the value lines up with the write iterator of the bank
    assign filt = (x_mid <<< 1) - x_prev - x_next;

endmodule

`default_nettype wire

// File: filtered_ram/filtered_ram_dp.sv
`timescale 1ns/100ps
`default_nettype none

`include "fbp_defs.svh"

module filtered_ram_dp
(
    input  wire logic             clk,
    input  wire logic             we,
    input  wire fbp_pkg::s_addr_t waddr,
    input  wire fbp_pkg::filt_t   wdata,
    input  wire fbp_pkg::s_addr_t raddr_0,
    input  wire fbp_pkg::s_addr_t raddr_1,
    output fbp_pkg::filt_t        rdata_0,
    output fbp_pkg::filt_t        rdata_1
);

    fbp_pkg::filt_t mem [0:`FBP_LINE_SIZE-1];

    // port 0 follows the write address during a write
    fbp_pkg::s_addr_t addr_0;

    assign addr_0 = we ? waddr : raddr_0;

    always_ff @(posedge clk)
    begin
        if (we)
            mem[waddr] <= wdata;
        rdata_0 <= mem[addr_0];
        rdata_1 <= mem[raddr_1];
    end

endmodule

`default_nettype wire

// File: filtered_ram/filtered_ram_swappable.sv
`timescale 1ns/100ps
`default_nettype none

`include "fbp_defs.svh"

module filtered_ram_swappable
(
    input  wire logic             clk,
    input  wire logic             reset_n,
    input  wire logic             fill_kick,
    input  wire fbp_pkg::filt_t   filt,
    input  wire fbp_pkg::pr_req_t pr_req,
    output logic                  fill_done,
    output fbp_pkg::s_addr_t      sample_addr,
    output fbp_pkg::pr_rsp_t      pr_rsp
);

    localparam fbp_pkg::s_addr_t last_addr  = fbp_pkg::s_addr_t'(`FBP_LINE_SIZE - 1);
    localparam fbp_pkg::s_addr_t delay_last = fbp_pkg::s_addr_t'(`FBP_FIR_ORDER / 2 - 1);

    fbp_pkg::fill_state_t state;
    fbp_pkg::fill_state_t next_state;

    fbp_pkg::s_addr_t read_itr;
    fbp_pkg::s_addr_t write_itr;

    logic             write_enable;
    logic             delay_done;
    logic             fill_last;
    fbp_pkg::s_addr_t pr0_addr_m;
    fbp_pkg::filt_t   rdata_0;
    fbp_pkg::filt_t   rdata_1;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
            state <= fbp_pkg::ready_s;
        else
            state <= next_state;
    end

    // read iterator runs ahead of the write iterator by the filter delay
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            read_itr  <= '0;
            write_itr <= '0;
        end
        else if (state == fbp_pkg::ready_s || fill_last)
        begin
            read_itr  <= '0;
            write_itr <= '0;
        end
        else if (state == fbp_pkg::delay_s)
        begin
            read_itr <= read_itr + 1'b1;
        end
        else
        begin
            write_itr <= write_itr + 1'b1;
            // hold on the last sample, it stands in for x[16]
            if (read_itr != last_addr)
                read_itr <= read_itr + 1'b1;
        end
    end

    assign write_enable = (state == fbp_pkg::fill_s);
    assign delay_done   = (read_itr == delay_last);
    assign fill_last    = write_enable && (write_itr == last_addr);

    // done pulse as the last value goes in
    assign fill_done   = fill_last;
    assign sample_addr = read_itr;

    always_comb
    begin
        next_state = state;
        case (state)
            fbp_pkg::ready_s:
                if (fill_kick)
                    next_state = fbp_pkg::delay_s;
            fbp_pkg::delay_s:
                if (delay_done)
                    next_state = fbp_pkg::fill_s;
            fbp_pkg::fill_s:
                if (fill_last)
                    next_state = fbp_pkg::ready_s;
            default:
                next_state = fbp_pkg::ready_s;
        endcase
    end

    // bank is not serving while it fills, so port 0 can be borrowed
    assign pr0_addr_m = (state == fbp_pkg::ready_s) ? pr_req.pr0 : write_itr;

    filtered_ram_dp ram
    (
        .clk     (clk),
        .we      (write_enable),
        .waddr   (write_itr),
        .wdata   (filt),
        .raddr_0 (pr0_addr_m),
        .raddr_1 (pr_req.pr1),
        .rdata_0 (rdata_0),
        .rdata_1 (rdata_1)
    );

    assign pr_rsp.pr0 = rdata_0;
    assign pr_rsp.pr1 = rdata_1;

endmodule

`default_nettype wire

// File: design/bank_swap_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

`include "fbp_defs.svh"

module bank_swap_ctrl
(
    input  wire logic             clk,
    input  wire logic             reset_n,
    input  wire logic             fill_kick,
    input  wire logic             swap,
    input  wire logic             done_0,
    input  wire logic             done_1,
    input  wire fbp_pkg::s_addr_t addr_0,
    input  wire fbp_pkg::s_addr_t addr_1,
    input  wire fbp_pkg::pr_rsp_t rsp_0,
    input  wire fbp_pkg::pr_rsp_t rsp_1,
    output logic                  kick_0,
    output logic                  kick_1,
    output logic                  fill_done,
    output fbp_pkg::s_addr_t      sample_addr,
    output fbp_pkg::pr_rsp_t      pr_rsp,
    output logic                  serve_bank
);

    // bank being filled, the other one serves
    logic fill_bank;
    // set from an accepted kick until that bank reports done
    logic busy;

    logic done_sel;
    logic kick_ok;
    logic swap_ok;

    assign done_sel = fill_bank ? done_1 : done_0;
    assign kick_ok  = fill_kick && !busy;

    // no swap from the kick cycle through the done cycle
    assign swap_ok = swap && !busy && !fill_kick && !done_sel;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            fill_bank <= 1'b0;
            busy      <= 1'b0;
        end
        else
        begin
            if (kick_ok)
                busy <= 1'b1;
            else if (done_sel)
                busy <= 1'b0;

            if (swap_ok)
                fill_bank <= ~fill_bank;
        end
    end

    // kick only reaches the filling bank
    assign kick_0 = kick_ok && !fill_bank;
    assign kick_1 = kick_ok && fill_bank;

    // host side follows the filling bank
    assign fill_done   = done_sel;
    assign sample_addr = fill_bank ? addr_1 : addr_0;

    // processors see the serving bank
    assign serve_bank = ~fill_bank;
    assign pr_rsp     = fill_bank ? rsp_0 : rsp_1;

endmodule

`default_nettype wire

// File: design/fbp_filter_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "fbp_defs.svh"

module fbp_filter_top
(
    input  wire logic             clk,
    input  wire logic             reset_n,
    input  wire logic             fill_kick,
    input  wire logic             swap,
    input  wire fbp_pkg::sample_t sample,
    input  wire fbp_pkg::pr_req_t pr_req,
    output fbp_pkg::s_addr_t      sample_addr,
    output logic                  fill_done,
    output fbp_pkg::pr_rsp_t      pr_rsp,
    output logic                  serve_bank
);

    // filtered stream shared by both banks
    fbp_pkg::filt_t filt;

    logic kick_0;
    logic kick_1;
    logic done_0;
    logic done_1;

    fbp_pkg::s_addr_t addr_0;
    fbp_pkg::s_addr_t addr_1;
    fbp_pkg::pr_rsp_t rsp_0;
    fbp_pkg::pr_rsp_t rsp_1;

    ramp_fir fir
    (
        .clk     (clk),
        .reset_n (reset_n),
        .clear   (fill_kick),
        .sample  (sample),
        .filt    (filt)
    );

    filtered_ram_swappable bank_0
    (
        .clk         (clk),
        .reset_n     (reset_n),
        .fill_kick   (kick_0),
        .filt        (filt),
        .pr_req      (pr_req),
        .fill_done   (done_0),
        .sample_addr (addr_0),
        .pr_rsp      (rsp_0)
    );

    filtered_ram_swappable bank_1
    (
        .clk         (clk),
        .reset_n     (reset_n),
        .fill_kick   (kick_1),
        .filt        (filt),
        .pr_req      (pr_req),
        .fill_done   (done_1),
        .sample_addr (addr_1),
        .pr_rsp      (rsp_1)
    );

    bank_swap_ctrl swap_ctrl
    (
        .clk         (clk),
        .reset_n     (reset_n),
        .fill_kick   (fill_kick),
        .swap        (swap),
        .done_0      (done_0),
        .done_1      (done_1),
        .addr_0      (addr_0),
        .addr_1      (addr_1),
        .rsp_0       (rsp_0),
        .rsp_1       (rsp_1),
        .kick_0      (kick_0),
        .kick_1      (kick_1),
        .fill_done   (fill_done),
        .sample_addr (sample_addr),
        .pr_rsp      (pr_rsp),
        .serve_bank  (serve_bank)
    );

endmodule

`default_nettype wire

// File: dv/fbp_filter_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "fbp_defs.svh"

module fbp_filter_tb;

    typedef enum logic [1:0] {
        op_fill,
        op_swap,
        op_swap_during_fill,
        op_read_check
    } op_t;

    // one stimulus row with its expected serving bank
    typedef struct packed {
        op_t        op;
        logic [1:0] line_id;
        logic       serve;
    } row_t;

    localparam int num_rows  = 13;
    localparam int wait_max  = 40;
    localparam int fill_time = 17;

    logic             clk;
    logic             reset_n;
    logic             fill_kick;
    logic             swap;
    fbp_pkg::sample_t sample;
    fbp_pkg::pr_req_t pr_req;
    fbp_pkg::s_addr_t sample_addr;
    logic             fill_done;
    fbp_pkg::pr_rsp_t pr_rsp;
    logic             serve_bank;

    fbp_pkg::sample_t lines [0:3][0:`FBP_LINE_SIZE-1];
    fbp_pkg::filt_t   exp_filt [0:3][0:`FBP_LINE_SIZE-1];
    fbp_pkg::sample_t host_line [0:`FBP_LINE_SIZE-1];
    row_t             table_rows [0:num_rows-1];

    int row_errors;
    int value_errors;
    int pass_rows;
    int fail_rows;
    // line held by the serving bank and by the filling bank, -1 if none
    int serve_line;
    int filled_line;
    int seed_draw;

    fbp_filter_top uut
    (
        .clk         (clk),
        .reset_n     (reset_n),
        .fill_kick   (fill_kick),
        .swap        (swap),
        .sample      (sample),
        .pr_req      (pr_req),
        .sample_addr (sample_addr),
        .fill_done   (fill_done),
        .pr_rsp      (pr_rsp),
        .serve_bank  (serve_bank)
    );

    always #10 clk = ~clk;

    // host memory answers the requested address
    always @(posedge clk)
    begin
        #1;
        sample = host_line[sample_addr];
    end

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    function automatic string op_label(input op_t op);
        string s;
        case (op)
            op_fill:
                s = "fill";
            op_swap:
                s = "swap";
            op_swap_during_fill:
                s = "swap_during_fill";
            default:
                s = "read_check";
        endcase
        return s;
    endfunction

    // ramp rule with zero before the line and the last sample repeated after it
    function automatic fbp_pkg::filt_t ref_filter(input int line_id, input int idx);
        int x_prev;
        int x_mid;
        int x_next;
        begin
            x_mid = lines[line_id][idx];
            if (idx == 0)
                x_prev = 0;
            else
                x_prev = lines[line_id][idx-1];
            if (idx == `FBP_LINE_SIZE - 1)
                x_next = lines[line_id][idx];
            else
                x_next = lines[line_id][idx+1];
            return fbp_pkg::filt_t'(2 * x_mid - x_prev - x_next);
        end
    endfunction

    task automatic load_stimulus();
        for (int i = 0; i < `FBP_LINE_SIZE; i++)
        begin
            lines[0][i] = fbp_pkg::sample_t'($urandom);
            lines[1][i] = fbp_pkg::sample_t'(i * 150 - 1100);
            lines[2][i] = fbp_pkg::sample_t'(2047);
            lines[3][i] = (i % 2 == 0) ? fbp_pkg::sample_t'(2047) : fbp_pkg::sample_t'(-2048);
        end
        for (int l = 0; l < 4; l++)
            for (int i = 0; i < `FBP_LINE_SIZE; i++)
                exp_filt[l][i] = ref_filter(l, i);

        table_rows[0]  = '{op_fill,             2'd0, 1'b1};
        table_rows[1]  = '{op_swap,             2'd0, 1'b0};
        table_rows[2]  = '{op_read_check,       2'd0, 1'b0};
        table_rows[3]  = '{op_fill,             2'd1, 1'b0};
        table_rows[4]  = '{op_swap,             2'd1, 1'b1};
        table_rows[5]  = '{op_read_check,       2'd1, 1'b1};
        table_rows[6]  = '{op_swap_during_fill, 2'd2, 1'b1};
        table_rows[7]  = '{op_read_check,       2'd1, 1'b1};
        table_rows[8]  = '{op_swap,             2'd2, 1'b0};
        table_rows[9]  = '{op_read_check,       2'd2, 1'b0};
        table_rows[10] = '{op_fill,             2'd3, 1'b0};
        table_rows[11] = '{op_swap,             2'd3, 1'b1};
        table_rows[12] = '{op_read_check,       2'd3, 1'b1};
    endtask

    // check the data for step i-1, then request step i
    task automatic read_step(input int i, input int line_id);
        int a;
        begin
            if (i > 0)
            begin
                a = i - 1;
                if (pr_rsp.pr0 !== exp_filt[line_id][a])
                begin
                    $display("** Error at %0t: pr0 addr %0d expected %0d, got %0d",
                             $time, a, exp_filt[line_id][a], pr_rsp.pr0);
                    row_errors++;
                end
                if (pr_rsp.pr1 !== exp_filt[line_id][15-a])
                begin
                    $display("** Error at %0t: pr1 addr %0d expected %0d, got %0d",
                             $time, 15 - a, exp_filt[line_id][15-a], pr_rsp.pr1);
                    row_errors++;
                end
            end
            if (i < `FBP_LINE_SIZE)
            begin
                pr_req.pr0 = fbp_pkg::s_addr_t'(i);
                pr_req.pr1 = fbp_pkg::s_addr_t'(15 - i);
            end
        end
    endtask

    task automatic check_serve(input logic expected);
        if (serve_bank !== expected)
        begin
            $display("** Error at %0t: serve_bank expected %0d, got %0d",
                     $time, expected, serve_bank);
            row_errors++;
        end
    endtask

    // fill one line, reading the serving bank alongside when it holds data
    task automatic run_fill(input int line_id, input logic swap_mid, input logic exp_serve);
        int n;
        int done_at;
        int read_line;
        int exp_addr;
        begin
            read_line = serve_line;
            for (int i = 0; i < `FBP_LINE_SIZE; i++)
                host_line[i] = lines[line_id][i];
            next_cycle();
            fill_kick = 1'b1;
            n = 0;
            done_at = 0;
            while (done_at == 0 && n < wait_max)
            begin
                if (read_line >= 0 && n <= `FBP_LINE_SIZE)
                    read_step(n, read_line);
                if (swap_mid)
                    swap = (n == 8);
                next_cycle();
                fill_kick = 1'b0;
                n++;
                // host address trails the cycle count by one, holds at the line end
                exp_addr = (n - 1 < `FBP_LINE_SIZE) ? n - 1 : `FBP_LINE_SIZE - 1;
                if (n <= fill_time && sample_addr !== fbp_pkg::s_addr_t'(exp_addr))
                begin
                    $display("** Error at %0t: sample_addr expected %0d, got %0d",
                             $time, exp_addr, sample_addr);
                    row_errors++;
                end
                if (fill_done)
                    done_at = n;
            end
            swap = 1'b0;
            if (done_at == 0)
            begin
                $display("timeout: fill_done never came within %0d cycles of the kick",
                         wait_max);
                row_errors++;
            end
            else if (done_at != fill_time)
            begin
                $display("** Error at %0t: fill_done after %0d cycles, expected %0d",
                         $time, done_at, fill_time);
                row_errors++;
            end
            // a swap in the done cycle must be dropped as well
            if (swap_mid)
                swap = 1'b1;
            next_cycle();
            swap = 1'b0;
            if (fill_done !== 1'b0)
            begin
                $display("** Error at %0t: fill_done still high after the fill", $time);
                row_errors++;
            end
            if (sample_addr !== '0)
            begin
                $display("** Error at %0t: sample_addr expected 0 after the fill, got %0d",
                         $time, sample_addr);
                row_errors++;
            end
            filled_line = line_id;
            check_serve(exp_serve);
        end
    endtask

    task automatic run_swap(input logic exp_serve);
        int held;
        begin
            swap = 1'b1;
            next_cycle();
            swap = 1'b0;
            check_serve(exp_serve);
            held = serve_line;
            serve_line = filled_line;
            filled_line = held;
        end
    endtask

    task automatic run_read_check(input int line_id, input logic exp_serve);
        for (int i = 0; i <= `FBP_LINE_SIZE; i++)
        begin
            read_step(i, line_id);
            next_cycle();
        end
        check_serve(exp_serve);
    endtask

    initial
    begin
        clk = 1'b0;
        reset_n = 1'b0;
        fill_kick = 1'b0;
        swap = 1'b0;
        sample = '0;
        pr_req = '0;
        row_errors = 0;
        value_errors = 0;
        pass_rows = 0;
        fail_rows = 0;
        serve_line = -1;
        filled_line = -1;
        seed_draw = $urandom(6921);
        for (int i = 0; i < `FBP_LINE_SIZE; i++)
            host_line[i] = '0;
        load_stimulus();

        repeat (16) @(posedge clk);
        #1;
        reset_n = 1'b1;

        // idle after reset, no kick given
        for (int c = 0; c < 5; c++)
        begin
            next_cycle();
            check_serve(1'b1);
            if (fill_done !== 1'b0)
            begin
                $display("** Error at %0t: fill_done high with no kick", $time);
                row_errors++;
            end
            if (sample_addr !== '0)
            begin
                $display("** Error at %0t: sample_addr expected 0 while idle, got %0d",
                         $time, sample_addr);
                row_errors++;
            end
        end
        if (row_errors == 0)
            pass_rows++;
        else
            fail_rows++;
        $display("reset idle check: %s", (row_errors == 0) ? "pass" : "fail");
        value_errors += row_errors;

        for (int r = 0; r < num_rows; r++)
        begin
            row_errors = 0;
            case (table_rows[r].op)
                op_fill:
                    run_fill(table_rows[r].line_id, 1'b0, table_rows[r].serve);
                op_swap_during_fill:
                    run_fill(table_rows[r].line_id, 1'b1, table_rows[r].serve);
                op_swap:
                    run_swap(table_rows[r].serve);
                default:
                    run_read_check(table_rows[r].line_id, table_rows[r].serve);
            endcase
            if (row_errors == 0)
                pass_rows++;
            else
                fail_rows++;
            $display("row %0d %s line %0d: %s", r, op_label(table_rows[r].op),
                     table_rows[r].line_id, (row_errors == 0) ? "pass" : "fail");
            value_errors += row_errors;
        end

        $display("checks passed %0d, failed %0d, errors %0d", pass_rows, fail_rows,
                 value_errors);
        if (fail_rows == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
+incdir+common
common/fbp_pkg.sv
design/ramp_fir.sv
filtered_ram/filtered_ram_dp.sv
filtered_ram/filtered_ram_swappable.sv
design/bank_swap_ctrl.sv
design/fbp_filter_top.sv
dv/fbp_filter_tb.sv
